/* files.f */
common/gameTypesPkg.sv
common/fieldGeomPkg.sv
hdl/tickGen.sv
hdl/buttonPanel.sv
arena/targetMotion.sv
arena/projectileFlight.sv
arena/hitJudge.sv
hdl/gameControl.sv
hdl/gameTop.sv
test/gameTb.sv

/* run.sh */
#!/bin/sh
# Build and run the game testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module gameTb -o gameSim

out=$(./obj_dir/gameSim)
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

/* test/gameTb.sv */
`timescale 1ns/10ps

module gameTb;
    import gameTypesPkg::*;
    import fieldGeomPkg::*;

    logic       FPGA_CLK;
    logic       RESET;
    logic       powerUp;
    logic       powerDown;
    logic       throwBtn;
    logic       gameLevel;
    logic       wind;
    logic       weapon;
    score_t     score;
    logic [3:0] power;
    hitResult_e hitResult;
    flight_t    flight;
    gridPos_t   dogPos;
    logic [2:0] wallHigh;

    int         seed = 32'hcd2f;
    int         errCount = 0;
    int         timeoutCount = 0;
    logic [3:0] modelPower;

    // Previous sample and model direction state
    score_t     pScore;
    logic [3:0] pPower;
    flight_t    pFlight;
    gridPos_t   pDog;
    logic [2:0] pWall;
    hitResult_e lastEvent;
    logic       dogLeft;
    logic       wallUp;

    gameTop #(.STATE_DIV(8), .BTN_DIV(2)) UUT (.*);

    initial FPGA_CLK = 1'b0;
    always #50 FPGA_CLK = ~FPGA_CLK;

    function automatic int randRange(input int n);
        randRange = ($random(seed) & 32'h7fffffff) % n;
    endfunction

    task automatic valueError(input string name, input logic [31:0] expVal,
                              input logic [31:0] gotVal);
        $display("ERROR %s expected %h got %h", name, expVal, gotVal);
        errCount++;
    endtask

    task automatic ruleError(input string msg);
        $display("Check failed: %s", msg);
        errCount++;
    endtask

    // Dog bounces between DOG_MIN and DOG_MAX
    function automatic gridPos_t stepDog(input gridPos_t d, input logic left);
        gridPos_t n;
        n.y = START_ROW;
        if (left) n.x = (d.x == DOG_MIN) ? DOG_MIN + 5'd1 : d.x - 5'd1;
        else n.x = (d.x == DOG_MAX) ? DOG_MAX - 5'd1 : d.x + 5'd1;
        return n;
    endfunction

    function automatic logic [2:0] stepWall(input logic [2:0] w, input logic up);
        return up ? ((w == 3'd0) ? 3'd1 : w - 3'd1)
                  : ((w == WALL_LOW) ? WALL_LOW - 3'd1 : w + 3'd1);
    endfunction

    function automatic flight_t stepFlight(input flight_t f, input logic [3:0] pw,
                                           input logic wd);
        logic [4:0] speed;
        flight_t    n;
        speed = 5'd1 + {1'b0, pw} + {4'd0, wd};
        n.prevX = f.pos.x;
        n.pos.x = f.pos.x + speed;
        if (f.pos.x < WALL_COL) begin
            n.pos.y = f.pos.y - 4'd1;
        end else if (f.pos.x >= OUT_COL) begin
            n.pos.x = 5'd0;
            n.pos.y = START_ROW;
        end else begin
            n.pos.y = f.pos.y + 4'd1;
        end
        return n;
    endfunction

    function automatic hitResult_e classifyHit(input flight_t f, input gridPos_t d,
                                               input logic [2:0] w);
        if (f.pos.x >= OUT_COL && f.pos.y != GROUND_ROW) return MISS;
        if (f.prevX < WALL_COL && f.pos.x >= WALL_COL && f.pos.y >= {1'b0, w}) return MISS;
        if ((f.pos.x == d.x || f.pos.x == d.x + 5'd1)
            && (f.pos.y == d.y || f.pos.y == d.y + 4'd1)) return HIT;
        if (f.pos.y == GROUND_ROW) return MISS;
        return NO_EVENT;
    endfunction

    function automatic score_t nextScore(input score_t s, input hitResult_e ev,
                                         input logic wpn);
        score_t     n;
        logic [3:0] dmg;
        n = s;
        dmg = wpn ? BOMB_DAMAGE : BONE_DAMAGE;
        if (s.state == MOVE) begin
            n.state = THROW;
            n.chance = s.chance - 4'd1;
        end else if (s.state == THROW && ev == HIT && s.life <= dmg) begin
            n.state = SUCCESS;
            n.life = 4'd0;
        end else if (s.state == THROW && ev != NO_EVENT) begin
            n.state = (s.chance == 4'd0) ? FAIL : MOVE;
            if (ev == HIT) n.life = s.life - dmg;
        end
        return n;
    endfunction

    // Outputs are stable at the falling edge
    always @(negedge FPGA_CLK) begin : sampleCheck
        logic       active;
        flight_t    expFlight;
        hitResult_e expHit;
        score_t     expScore;
        if (!RESET) begin
            dogLeft = 1'b1;
            wallUp = 1'b1;
        end else begin
            active = (pScore.state == MOVE || pScore.state == THROW);
            if (dogPos !== pDog) begin
                if (!active) ruleError("dog moved after the game ended");
                if (dogPos !== stepDog(pDog, dogLeft))
                    valueError("dogPos", 32'(stepDog(pDog, dogLeft)), 32'(dogPos));
                dogLeft = dogLeft ? (pDog.x != DOG_MIN) : (pDog.x == DOG_MAX);
            end
            if (!gameLevel) begin
                wallUp = 1'b1;
                if (wallHigh !== WALL_LOW) valueError("wallHigh", 32'(WALL_LOW), 32'(wallHigh));
            end else if (wallHigh !== pWall) begin
                if (!active) ruleError("wall moved after the game ended");
                if (wallHigh !== stepWall(pWall, wallUp))
                    valueError("wallHigh", 32'(stepWall(pWall, wallUp)), 32'(wallHigh));
                wallUp = wallUp ? (pWall != 3'd0) : (pWall == WALL_LOW);
            end
            if (flight !== pFlight && active) begin
                if (pScore.state == MOVE) begin
                    expFlight = {5'd0, START_ROW, 5'd0};
                end else begin
                    expFlight = stepFlight(pFlight, pPower, wind);
                end
                if (flight !== expFlight) valueError("flight", 32'(expFlight), 32'(flight));
            end
            if (!active && flight.pos !== {PARK_COL, START_ROW})
                valueError("flight.pos", 32'({PARK_COL, START_ROW}), 32'(flight.pos));
            expHit = (score.state == THROW) ? classifyHit(flight, dogPos, wallHigh) : NO_EVENT;
            if (hitResult !== expHit) valueError("hitResult", 32'(expHit), 32'(hitResult));
            if (score !== pScore) begin
                expScore = nextScore(pScore, lastEvent, weapon);
                if (score !== expScore) valueError("score", 32'(expScore), 32'(score));
            end
        end
        if (score.state != THROW) lastEvent = NO_EVENT;
        else if (hitResult != NO_EVENT) lastEvent = hitResult;
        pScore = score;
        pPower = power;
        pFlight = flight;
        pDog = dogPos;
        pWall = wallHigh;
    end

    task automatic resetDesign();
        @(posedge FPGA_CLK);
        #5;
        RESET = 1'b0;
        gameLevel = (randRange(2) == 1);
        wind = (randRange(2) == 1);
        weapon = (randRange(2) == 1);
        repeat (3) @(posedge FPGA_CLK);
        #5;
        RESET = 1'b1;
        modelPower = 4'd0;
    endtask

    // One hold and release; both last several button ticks
    task automatic pressButton(input int which);
        int hold;
        int gap;
        hold = 2 * (3 + randRange(4));
        gap = 2 * (3 + randRange(4));
        @(posedge FPGA_CLK);
        #5;
        powerUp = (which == 0);
        powerDown = (which == 1);
        throwBtn = (which == 2);
        repeat (hold) @(posedge FPGA_CLK);
        #5;
        powerUp = 1'b0;
        powerDown = 1'b0;
        throwBtn = 1'b0;
        repeat (gap) @(posedge FPGA_CLK);
        if (which == 0 && modelPower < MAX_POWER) modelPower = modelPower + 4'd1;
        if (which == 1 && modelPower != 4'd0) modelPower = modelPower - 4'd1;
        @(negedge FPGA_CLK);
        if (power !== modelPower) valueError("power", 32'(modelPower), 32'(power));
    endtask

    task automatic playGame();
        int actions;
        int choice;
        resetDesign();
        @(negedge FPGA_CLK);
        if (score !== {MOVE, START_CHANCE, START_LIFE})
            valueError("score", 32'({MOVE, START_CHANCE, START_LIFE}), 32'(score));
        if (power !== 4'd0) valueError("power", 32'(0), 32'(power));
        if (hitResult !== NO_EVENT) valueError("hitResult", 32'(NO_EVENT), 32'(hitResult));
        if (dogPos !== {DOG_MAX, START_ROW})
            valueError("dogPos", 32'({DOG_MAX, START_ROW}), 32'(dogPos));
        if (wallHigh !== WALL_LOW) valueError("wallHigh", 32'(WALL_LOW), 32'(wallHigh));
        if (flight.pos !== {5'd0, START_ROW})
            valueError("flight.pos", 32'({5'd0, START_ROW}), 32'(flight.pos));
        actions = 0;
        while ((score.state == MOVE || score.state == THROW) && actions < 300) begin
            choice = randRange(4);
            pressButton(choice > 2 ? 2 : choice);
            actions++;
        end
        if (score.state == MOVE || score.state == THROW) begin
            $display("Timeout: the game did not end within %0d button actions", actions);
            timeoutCount++;
        end
        // Let the monitor watch the frozen end state
        repeat (64) @(posedge FPGA_CLK);
    endtask

    initial begin
        int game;
        RESET = 1'b0;
        powerUp = 1'b0;
        powerDown = 1'b0;
        throwBtn = 1'b0;
        gameLevel = 1'b0;
        wind = 1'b0;
        weapon = 1'b0;
        modelPower = 4'd0;
        for (game = 0; game < 6; game++) begin
            playGame();
        end
        $display("Errors: %0d, timeouts: %0d", errCount, timeoutCount);
        if (errCount == 0 && timeoutCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* hdl/gameTop.sv */
`timescale 1ns/10ps

module gameTop #(
    parameter int STATE_DIV = 25_000_000,
    parameter int BTN_DIV = 2_000_000
) (
    input  logic                     FPGA_CLK,
    input  logic                     RESET,
    input  logic                     powerUp,
    input  logic                     powerDown,
    input  logic                     throwBtn,
    input  logic                     gameLevel,
    input  logic                     wind,
    input  logic                     weapon,
    output gameTypesPkg::score_t     score,
    output logic [3:0]               power,
    output gameTypesPkg::hitResult_e hitResult,
    output gameTypesPkg::flight_t    flight,
    output gameTypesPkg::gridPos_t   dogPos,
    output logic [2:0]               wallHigh
);
    logic btnTick;
    logic stateTick;
    logic moveTick;
    logic throwPulse;

    tickGen #(
        .STATE_DIV(STATE_DIV),
        .BTN_DIV(BTN_DIV)
    ) ticks (
        .FPGA_CLK(FPGA_CLK),
        .RESET(RESET),
        .btnTick(btnTick),
        .stateTick(stateTick),
        .moveTick(moveTick)
    );

    buttonPanel buttons (
        .FPGA_CLK(FPGA_CLK),
        .RESET(RESET),
        .btnTick(btnTick),
        .powerUp(powerUp),
        .powerDown(powerDown),
        .throwBtn(throwBtn),
        .power(power),
        .throwPulse(throwPulse)
    );

    targetMotion target (
        .FPGA_CLK(FPGA_CLK),
        .RESET(RESET),
        .moveTick(moveTick),
        .gameLevel(gameLevel),
        .state(score.state),
        .dogPos(dogPos),
        .wallHigh(wallHigh)
    );

    projectileFlight projectile (
        .FPGA_CLK(FPGA_CLK),
        .RESET(RESET),
        .moveTick(moveTick),
        .state(score.state),
        .power(power),
        .wind(wind),
        .flight(flight)
    );

    hitJudge judge (
        .state(score.state),
        .flight(flight),
        .dogPos(dogPos),
        .wallHigh(wallHigh),
        .hitResult(hitResult)
    );

    gameControl control (
        .FPGA_CLK(FPGA_CLK),
        .RESET(RESET),
        .stateTick(stateTick),
        .throwPulse(throwPulse),
        .hitResult(hitResult),
        .weapon(weapon),
        .score(score)
    );

endmodule

/* hdl/gameControl.sv */
`timescale 1ns/10ps

module gameControl (
    input  logic                     FPGA_CLK,
    input  logic                     RESET,
    input  logic                     stateTick,
    input  logic                     throwPulse,
    input  gameTypesPkg::hitResult_e hitResult,
    input  logic                     weapon,
    output gameTypesPkg::score_t     score
);
    import gameTypesPkg::*;
    import fieldGeomPkg::*;

    logic       throwReq;
    logic       startThrow;
    logic [3:0] damage;

    assign damage = weapon ? BOMB_DAMAGE : BONE_DAMAGE;
    assign startThrow = stateTick && (score.state == MOVE) && throwReq;

    // Holds a throw press until the next state tick
    always_ff @(posedge FPGA_CLK or negedge RESET) begin
        if (!RESET) begin
            throwReq <= 1'b0;
        end else if (startThrow) begin
            throwReq <= 1'b0;
        end else if (throwPulse && score.state == MOVE) begin
            throwReq <= 1'b1;
        end
    end

    always_ff @(posedge FPGA_CLK or negedge RESET) begin
        if (!RESET) begin
            score.state <= MOVE;
            score.chance <= START_CHANCE;
            score.life <= START_LIFE;
        end else if (stateTick) begin
            case (score.state)
                MOVE: begin
                    if (throwReq) begin
                        score.state <= THROW;
                        score.chance <= score.chance - 4'd1;
                    end
                end
                THROW: begin
                    if (hitResult == HIT) begin
                        if (score.life <= damage) begin
                            score.state <= SUCCESS;
                            score.life <= 4'd0;
                        end else begin
                            score.life <= score.life - damage;
                            score.state <= (score.chance == 4'd0) ? FAIL : MOVE;
                        end
                    end else if (hitResult == MISS) begin
                        score.state <= (score.chance == 4'd0) ? FAIL : MOVE;
                    end
                end
                // Game over, hold
                default: score <= score;
            endcase
        end
    end

    lifeNeverRises: assert property (@(posedge FPGA_CLK) disable iff (!RESET)
        score.life <= $past(score.life));

endmodule

/* arena/hitJudge.sv */
`timescale 1ns/10ps

module hitJudge (
    input  gameTypesPkg::gameState_e state,
    input  gameTypesPkg::flight_t    flight,
    input  gameTypesPkg::gridPos_t   dogPos,
    input  logic [2:0]               wallHigh,
    output gameTypesPkg::hitResult_e hitResult
);
    import gameTypesPkg::*;
    import fieldGeomPkg::*;

    logic offField;
    logic hitWall;
    logic onDog;

    assign offField = (flight.pos.x >= OUT_COL) && (flight.pos.y != GROUND_ROW);
    // Crossed the wall column in the last step below its top
    assign hitWall = (flight.prevX < WALL_COL) && (flight.pos.x >= WALL_COL)
                     && (flight.pos.y >= {1'b0, wallHigh});
    // The dog covers a 2 by 2 block
    assign onDog = (flight.pos.x == dogPos.x || flight.pos.x == dogPos.x + 5'd1)
                   && (flight.pos.y == dogPos.y || flight.pos.y == dogPos.y + 4'd1);

    always_comb begin
        hitResult = NO_EVENT;
        if (state == THROW) begin
            if (offField || hitWall) begin
                hitResult = MISS;
            end else if (onDog) begin
                hitResult = HIT;
            end else if (flight.pos.y == GROUND_ROW) begin
                hitResult = MISS;
            end
        end
    end

endmodule

/* arena/projectileFlight.sv */
`timescale 1ns/10ps

module projectileFlight (
    input  logic                     FPGA_CLK,
    input  logic                     RESET,
    input  logic                     moveTick,
    input  gameTypesPkg::gameState_e state,
    input  logic [3:0]               power,
    input  logic                     wind,
    output gameTypesPkg::flight_t    flight
);
    import gameTypesPkg::*;
    import fieldGeomPkg::*;

    logic [4:0] speed;

    assign speed = 5'd1 + {1'b0, power} + {4'd0, wind};

    always_ff @(posedge FPGA_CLK or negedge RESET) begin
        if (!RESET) begin
            flight.pos.x <= 5'd0;
            flight.pos.y <= START_ROW;
            flight.prevX <= 5'd0;
        end else begin
            case (state)
                MOVE: begin
                    flight.pos.x <= 5'd0;
                    flight.pos.y <= START_ROW;
                    flight.prevX <= 5'd0;
                end
                THROW: begin
                    if (moveTick) begin
                        flight.prevX <= flight.pos.x;
                        if (flight.pos.x < WALL_COL) begin
                            // Rising toward the wall
                            flight.pos.x <= flight.pos.x + speed;
                            flight.pos.y <= flight.pos.y - 4'd1;
                        end else if (flight.pos.x >= OUT_COL) begin
                            flight.pos.x <= 5'd0;
                            flight.pos.y <= START_ROW;
                        end else begin
                            flight.pos.x <= flight.pos.x + speed;
                            flight.pos.y <= flight.pos.y + 4'd1;
                        end
                    end
                end
                default: begin
                    flight.pos.x <= PARK_COL;
                    flight.pos.y <= START_ROW;
                    flight.prevX <= PARK_COL;
                end
            endcase
        end
    end

    // Fastest step from the last field column
    flightInBounds: assert property (@(posedge FPGA_CLK) disable iff (!RESET)
        flight.pos.x <= 5'd21);

endmodule

/* arena/targetMotion.sv */
`timescale 1ns/10ps

module targetMotion (
    input  logic                     FPGA_CLK,
    input  logic                     RESET,
    input  logic                     moveTick,
    input  logic                     gameLevel,
    input  gameTypesPkg::gameState_e state,
    output gameTypesPkg::gridPos_t   dogPos,
    output logic [2:0]               wallHigh
);
    import gameTypesPkg::*;
    import fieldGeomPkg::*;

    logic dogLeft;
    logic wallUp;
    logic active;

    assign active = moveTick && (state == MOVE || state == THROW);

    // Dog paces between its two turning columns
    always_ff @(posedge FPGA_CLK or negedge RESET) begin
        if (!RESET) begin
            dogPos.x <= DOG_MAX;
            dogPos.y <= START_ROW;
            dogLeft <= 1'b1;
        end else if (active) begin
            dogPos.y <= START_ROW;
            if (dogLeft) begin
                if (dogPos.x == DOG_MIN) begin
                    dogPos.x <= DOG_MIN + 5'd1;
                    dogLeft <= 1'b0;
                end else begin
                    dogPos.x <= dogPos.x - 5'd1;
                end
            end else if (dogPos.x == DOG_MAX) begin
                dogPos.x <= DOG_MAX - 5'd1;
                dogLeft <= 1'b1;
            end else begin
                dogPos.x <= dogPos.x + 5'd1;
            end
        end
    end

    // Wall top row; a smaller value means a taller wall
    always_ff @(posedge FPGA_CLK or negedge RESET) begin
        if (!RESET) begin
            wallHigh <= WALL_LOW;
            wallUp <= 1'b1;
        end else if (!gameLevel) begin
            wallHigh <= WALL_LOW;
            wallUp <= 1'b1;
        end else if (active) begin
            if (wallUp) begin
                if (wallHigh == 3'd0) begin
                    wallHigh <= 3'd1;
                    wallUp <= 1'b0;
                end else begin
                    wallHigh <= wallHigh - 3'd1;
                end
            end else if (wallHigh == WALL_LOW) begin
                wallHigh <= WALL_LOW - 3'd1;
                wallUp <= 1'b1;
            end else begin
                wallHigh <= wallHigh + 3'd1;
            end
        end
    end

    dogInRange: assert property (@(posedge FPGA_CLK) disable iff (!RESET)
        dogPos.x >= DOG_MIN && dogPos.x <= DOG_MAX);

endmodule

/* hdl/buttonPanel.sv */
`timescale 1ns/10ps

module buttonPanel (
    input  logic       FPGA_CLK,
    input  logic       RESET,
    input  logic       btnTick,
    input  logic       powerUp,
    input  logic       powerDown,
    input  logic       throwBtn,
    output logic [3:0] power,
    output logic       throwPulse
);
    import fieldGeomPkg::*;

    // Index 0 is up, 1 is down, 2 is throw; bit 2 of each shift is the oldest sample
    logic [2:0][2:0] shift;
    logic [2:0]      rawBtn;
    logic [2:0]      press;

    assign rawBtn = {throwBtn, powerDown, powerUp};

    always_ff @(posedge FPGA_CLK or negedge RESET) begin
        if (!RESET) begin
            shift <= '0;
        end else if (btnTick) begin
            for (int i = 0; i < 3; i++) begin
                shift[i] <= {shift[i][1:0], rawBtn[i]};
            end
        end
    end

    // Released once, then held for two samples
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            press[i] = btnTick & (shift[i] == 3'b011);
        end
    end

    assign throwPulse = press[2];

    always_ff @(posedge FPGA_CLK or negedge RESET) begin
        if (!RESET) begin
            power <= 4'd0;
        end else if (press[0] && power < MAX_POWER) begin
            power <= power + 4'd1;
        end else if (press[1] && power != 4'd0) begin
            power <= power - 4'd1;
        end
    end

    powerClamped: assert property (@(posedge FPGA_CLK) disable iff (!RESET)
        power <= MAX_POWER);

endmodule

/* hdl/tickGen.sv */
`timescale 1ns/10ps

module tickGen #(
    parameter int STATE_DIV = 25_000_000,
    parameter int BTN_DIV = 2_000_000
) (
    input  logic FPGA_CLK,
    input  logic RESET,
    output logic btnTick,
    output logic stateTick,
    output logic moveTick
);
    localparam int STATE_W = $clog2(STATE_DIV);
    localparam int BTN_W = $clog2(BTN_DIV);
    localparam logic [STATE_W-1:0] STATE_LAST = STATE_W'(STATE_DIV - 1);
    localparam logic [BTN_W-1:0] BTN_LAST = BTN_W'(BTN_DIV - 1);

    logic [STATE_W-1:0] stateCnt;
    logic [BTN_W-1:0]   btnCnt;
    logic               moveToggle;

    assign stateTick = (stateCnt == STATE_LAST);
    assign btnTick = (btnCnt == BTN_LAST);
    // Every second state tick also moves things
    assign moveTick = stateTick & moveToggle;

    always_ff @(posedge FPGA_CLK or negedge RESET) begin
        if (!RESET) begin
            stateCnt <= '0;
            btnCnt <= '0;
            moveToggle <= 1'b0;
        end else begin
            stateCnt <= stateTick ? '0 : stateCnt + 1'b1;
            btnCnt <= btnTick ? '0 : btnCnt + 1'b1;
            if (stateTick) begin
                moveToggle <= ~moveToggle;
            end
        end
    end

endmodule

/* common/fieldGeomPkg.sv */
package fieldGeomPkg;

    // Columns
    localparam logic [4:0] WALL_COL = 5'd6;
    localparam logic [4:0] OUT_COL = 5'd16;
    localparam logic [4:0] PARK_COL = 5'd17;
    localparam logic [4:0] DOG_MIN = 5'd7;
    localparam logic [4:0] DOG_MAX = 5'd14;

    // Rows
    localparam logic [3:0] START_ROW = 4'd6;
    localparam logic [3:0] GROUND_ROW = 4'd7;
    localparam logic [2:0] WALL_LOW = 3'd5;

    // Game rules
    localparam logic [3:0] MAX_POWER = 4'd4;
    localparam logic [3:0] START_CHANCE = 4'd5;
    localparam logic [3:0] START_LIFE = 4'd9;
    localparam logic [3:0] BOMB_DAMAGE = 4'd4;
    localparam logic [3:0] BONE_DAMAGE = 4'd2;

endpackage

/* common/gameTypesPkg.sv */
package gameTypesPkg;

    typedef enum logic [1:0] {
        MOVE,
        THROW,
        SUCCESS,
        FAIL
    } gameState_e;

    typedef enum logic [1:0] {
        NO_EVENT,
        HIT,
        MISS
    } hitResult_e;

    // Column and row on the 16 by 8 grid, row 7 is the ground
    typedef struct packed {
        logic [4:0] x;
        logic [3:0] y;
    } gridPos_t;

    typedef struct packed {
        gridPos_t   pos;
        logic [4:0] prevX;
    } flight_t;

    typedef struct packed {
        gameState_e state;
        logic [3:0] chance;
        logic [3:0] life;
    } score_t;

endpackage
